// ==== verilog/memBusSettings.svh ====
`ifndef MEM_BUS_SETTINGS_SVH
`define MEM_BUS_SETTINGS_SVH

//////////////////////////////////////////////////
// Bus timing and decode
//////////////////////////////////////////////////

// Width of the step timer
// A step lasts 2**MEM_STEP_BITS clocks
`define MEM_STEP_BITS 2

// Serial port sits at one fixed word address
`define UART_ADDR 16'hBF00

// Result source codes on resultSel
`define RESULT_RAM1 2'd0
`define RESULT_RAM2 2'd1
`define RESULT_UART 2'd2

//////////////////////////////////////////////////
// Model sizes
//////////////////////////////////////////////////

`define SRAM_MODEL_WORDS 65536
`define UART_QUEUE_DEPTH 16

`endif

// ==== verilog/memBusPkg.sv ====
package memBusPkg;

	// Word types
	typedef logic [15:0] memAddrT;
	typedef logic [15:0] memValueT;
	typedef logic [7:0] uartByteT;

	// One CPU access
	typedef struct packed {
		logic write;
		memAddrT addr;
		memValueT value;
	} busReqT;

	// SRAM pin phases
	typedef enum logic [1:0] {
		sramOff,
		sramSetup,
		sramStrobe,
		sramFinish
	} sramStepT;

	// Serial chip pin phases
	typedef enum logic [2:0] {
		uartOff,
		uartLoadHigh,
		uartLoadLow,
		uartWriteStrobe,
		uartReadStrobe,
		uartCaptureHigh,
		uartCaptureLow
	} uartStepT;

	// Sequencer states, one per step
	typedef enum logic [4:0] {
		busIdle,
		ramSetup,
		ramStrobe,
		ramFinish,
		uartWrLoadHigh,
		uartWrStrobeHigh,
		uartWrTbreHigh,
		uartWrTsreHigh,
		uartWrLoadLow,
		uartWrStrobeLow,
		uartWrTbreLow,
		uartWrTsreLow,
		uartRdWaitHigh,
		uartRdStrobeHigh,
		uartRdCaptureHigh,
		uartRdWaitLow,
		uartRdStrobeLow,
		uartRdCaptureLow,
		uartFinish
	} busStateT;

endpackage

// ==== verilog/sramPort.sv ====
`timescale 1ns/10ps

module sramPort import memBusPkg::*; (
	input logic clk,
	input logic rst,
	input sramStepT step,
	input logic write,
	input memValueT value,
	input memAddrT addr,
	output memAddrT ramAddr,
	inout wire memValueT ramData,
	output logic ramEn,
	output logic ramOe,
	output logic ramWe,
	output memValueT readData
);

	logic busDrive;

	//////////////////////////////////////////////////
	// Pin registers
	//////////////////////////////////////////////////

	// Pins follow the step one clock late
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ramAddr <= '0;
			ramEn <= 1'b1;
			ramOe <= 1'b1;
			ramWe <= 1'b1;
		end else begin
			// Address holds its last value between accesses
			if (step != sramOff) begin
				ramAddr <= addr;
			end
			ramEn <= (step == sramOff);
			ramOe <= !(step == sramStrobe && !write);
			ramWe <= !(step == sramStrobe && write);
		end
	end

	//////////////////////////////////////////////////
	// Data bus
	//////////////////////////////////////////////////

	// Sample while OE is still low, as it rises
	always_ff @(posedge clk) begin
		if (!ramOe && step != sramStrobe) begin
			readData <= ramData;
		end
	end

	// Bus comes up one clock ahead of WE
	// and stays through the finish phase
	assign busDrive = write && (step == sramStrobe || step == sramFinish);
	assign ramData = busDrive ? value : 'z;

endmodule

// ==== verilog/uartPort.sv ====
`timescale 1ns/10ps

module uartPort import memBusPkg::*; (
	input logic clk,
	input logic rst,
	input uartStepT step,
	input memValueT value,
	inout wire uartByteT uartData,
	output logic rdn,
	output logic wrn,
	output memValueT readWord
);

	uartByteT txByte;
	logic driveHold;
	logic busDrive;

	//////////////////////////////////////////////////
	// Transmit side
	//////////////////////////////////////////////////

	// High byte goes out first
	always_ff @(posedge clk) begin
		if (step == uartLoadHigh) begin
			txByte <= value[15:8];
		end else if (step == uartLoadLow) begin
			txByte <= value[7:0];
		end
	end

	//////////////////////////////////////////////////
	// Strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rdn <= 1'b1;
			wrn <= 1'b1;
			driveHold <= 1'b0;
		end else begin
			rdn <= (step != uartReadStrobe);
			wrn <= (step != uartWriteStrobe);
			// One extra clock of drive after wrn rises
			driveHold <= !wrn;
		end
	end

	// Drive starts with the strobe step, a clock before wrn falls
	assign busDrive = (step == uartWriteStrobe) || !wrn || driveHold;
	assign uartData = busDrive ? txByte : 'z;

	//////////////////////////////////////////////////
	// Receive side
	//////////////////////////////////////////////////

	// Byte is taken on the clock where rdn goes back high
	always_ff @(posedge clk) begin
		if (!rdn && step == uartCaptureHigh) begin
			readWord[15:8] <= uartData;
		end
		if (!rdn && step == uartCaptureLow) begin
			readWord[7:0] <= uartData;
		end
	end

endmodule

// ==== verilog/memBusSequencer.sv ====
`timescale 1ns/10ps
`include "memBusSettings.svh"

module memBusSequencer import memBusPkg::*; (
	input logic clk,
	input logic rst,
	input logic work,
	input busReqT req,
	input logic dataReady,
	input logic tbre,
	input logic tsre,
	output sramStepT ram1Step,
	output sramStepT ram2Step,
	output uartStepT uartStep,
	output busReqT latchedReq,
	output logic workDone,
	output logic [1:0] resultSel
);

	logic [`MEM_STEP_BITS-1:0] stepCnt;
	logic stepEnd;
	logic stepNearEnd;
	logic accept;
	logic isUart;
	logic ram1Target;
	logic finishing;
	busStateT state;
	busStateT nextState;
	sramStepT ramPhase;

	//////////////////////////////////////////////////
	// Step timer
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stepCnt <= '0;
		end else begin
			stepCnt <= stepCnt + 1'b1;
		end
	end

	// Last clock of a step, and the one before it
	assign stepEnd = &stepCnt;
	assign stepNearEnd = (stepCnt == {{(`MEM_STEP_BITS-1){1'b1}}, 1'b0});

	//////////////////////////////////////////////////
	// Decode and accept
	//////////////////////////////////////////////////

	assign isUart = (req.addr == `UART_ADDR);
	assign accept = stepEnd && (state == busIdle) && work;

	always_ff @(posedge clk) begin
		if (accept) begin
			latchedReq <= req;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= busIdle;
			ram1Target <= 1'b0;
		end else if (stepEnd) begin
			state <= nextState;
			if (accept) begin
				ram1Target <= req.addr[15];
			end
		end
	end

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		case (state)
			busIdle: begin
				if (work) begin
					if (isUart) begin
						nextState = req.write ? uartWrLoadHigh : uartRdWaitHigh;
					end else begin
						nextState = ramSetup;
					end
				end
			end
			ramSetup: nextState = ramStrobe;
			ramStrobe: nextState = ramFinish;
			ramFinish: nextState = busIdle;

			// Serial write, then wait for both buffers to drain
			uartWrLoadHigh: nextState = uartWrStrobeHigh;
			uartWrStrobeHigh: nextState = uartWrTbreHigh;
			uartWrTbreHigh: nextState = tbre ? uartWrTsreHigh : uartWrTbreHigh;
			uartWrTsreHigh: nextState = tsre ? uartWrLoadLow : uartWrTsreHigh;
			uartWrLoadLow: nextState = uartWrStrobeLow;
			uartWrStrobeLow: nextState = uartWrTbreLow;
			uartWrTbreLow: nextState = tbre ? uartWrTsreLow : uartWrTbreLow;
			uartWrTsreLow: nextState = tsre ? uartFinish : uartWrTsreLow;

			// Serial read, one byte per dataReady
			uartRdWaitHigh: nextState = dataReady ? uartRdStrobeHigh : uartRdWaitHigh;
			uartRdStrobeHigh: nextState = uartRdCaptureHigh;
			uartRdCaptureHigh: nextState = uartRdWaitLow;
			uartRdWaitLow: nextState = dataReady ? uartRdStrobeLow : uartRdWaitLow;
			uartRdStrobeLow: nextState = uartRdCaptureLow;
			uartRdCaptureLow: nextState = uartFinish;
			uartFinish: nextState = busIdle;
			default: nextState = busIdle;
		endcase
	end

	//////////////////////////////////////////////////
	// Port steps
	//////////////////////////////////////////////////

	always_comb begin
		ramPhase = sramOff;
		uartStep = uartOff;
		case (state)
			ramSetup: ramPhase = sramSetup;
			ramStrobe: ramPhase = sramStrobe;
			ramFinish: ramPhase = sramFinish;
			uartWrLoadHigh: uartStep = uartLoadHigh;
			uartWrLoadLow: uartStep = uartLoadLow;
			uartWrStrobeHigh, uartWrStrobeLow: uartStep = uartWriteStrobe;
			uartRdStrobeHigh, uartRdStrobeLow: uartStep = uartReadStrobe;
			uartRdCaptureHigh: uartStep = uartCaptureHigh;
			uartRdCaptureLow: uartStep = uartCaptureLow;
			default: ;
		endcase
	end

	// Only the addressed chip sees a live phase
	assign ram1Step = ram1Target ? ramPhase : sramOff;
	assign ram2Step = ram1Target ? sramOff : ramPhase;

	//////////////////////////////////////////////////
	// Completion
	//////////////////////////////////////////////////

	assign finishing = (state == ramFinish) || (state == uartFinish);

	// Pulse sits in the last clock of the finish step
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			workDone <= 1'b0;
			resultSel <= `RESULT_RAM1;
		end else begin
			workDone <= finishing && stepNearEnd;
			if (finishing && stepNearEnd && !latchedReq.write) begin
				if (state == uartFinish) begin
					resultSel <= `RESULT_UART;
				end else if (ram1Target) begin
					resultSel <= `RESULT_RAM1;
				end else begin
					resultSel <= `RESULT_RAM2;
				end
			end
		end
	end

endmodule

// ==== verilog/memBusTop.sv ====
`timescale 1ns/10ps
`include "memBusSettings.svh"

module memBusTop import memBusPkg::*; (
	input logic clk,
	input logic rst,
	input logic work,
	input busReqT req,
	output logic workDone,
	output memValueT result,

	output memAddrT ram1Addr,
	inout wire memValueT ram1Data,
	output logic ram1En,
	output logic ram1Oe,
	output logic ram1We,

	output memAddrT ram2Addr,
	inout wire memValueT ram2Data,
	output logic ram2En,
	output logic ram2Oe,
	output logic ram2We,

	inout wire uartByteT uartData,
	output logic rdn,
	output logic wrn,
	input logic dataReady,
	input logic tbre,
	input logic tsre
);

	sramStepT ram1Step;
	sramStepT ram2Step;
	uartStepT uartStep;
	busReqT latchedReq;
	logic [1:0] resultSel;
	memValueT ram1Read;
	memValueT ram2Read;
	memValueT uartRead;

	memBusSequencer i_sequencer (
		.clk(clk),
		.rst(rst),
		.work(work),
		.req(req),
		.dataReady(dataReady),
		.tbre(tbre),
		.tsre(tsre),
		.ram1Step(ram1Step),
		.ram2Step(ram2Step),
		.uartStep(uartStep),
		.latchedReq(latchedReq),
		.workDone(workDone),
		.resultSel(resultSel)
	);

	// Chip 1 takes the upper half of the address space
	sramPort i_ram1Port (
		.clk(clk),
		.rst(rst),
		.step(ram1Step),
		.write(latchedReq.write),
		.value(latchedReq.value),
		.addr(latchedReq.addr),
		.ramAddr(ram1Addr),
		.ramData(ram1Data),
		.ramEn(ram1En),
		.ramOe(ram1Oe),
		.ramWe(ram1We),
		.readData(ram1Read)
	);

	sramPort i_ram2Port (
		.clk(clk),
		.rst(rst),
		.step(ram2Step),
		.write(latchedReq.write),
		.value(latchedReq.value),
		.addr(latchedReq.addr),
		.ramAddr(ram2Addr),
		.ramData(ram2Data),
		.ramEn(ram2En),
		.ramOe(ram2Oe),
		.ramWe(ram2We),
		.readData(ram2Read)
	);

	uartPort i_uartPort (
		.clk(clk),
		.rst(rst),
		.step(uartStep),
		.value(latchedReq.value),
		.uartData(uartData),
		.rdn(rdn),
		.wrn(wrn),
		.readWord(uartRead)
	);

	// Result follows the device of the last completed read
	always_comb begin
		case (resultSel)
			`RESULT_RAM1: result = ram1Read;
			`RESULT_RAM2: result = ram2Read;
			default: result = uartRead;
		endcase
	end

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/10ps

module tbClock (
	output logic clk,
	output logic rst
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held low for the first two clocks
	initial begin
		rst = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

// ==== test/memBusModels.sv ====
`timescale 1ns/10ps
`include "memBusSettings.svh"

//////////////////////////////////////////////////
// Asynchronous SRAM chip
//////////////////////////////////////////////////

module sramModel import memBusPkg::*; #(
	parameter memValueT fillMask = 16'h0000
) (
	input memAddrT addr,
	inout wire memValueT data,
	input logic en,
	input logic oe,
	input logic we
);

	memValueT mem [`SRAM_MODEL_WORDS];

	// Every word starts as its own address under a mask
	initial begin
		for (int i = 0; i < `SRAM_MODEL_WORDS; i++) begin
			mem[i] = memValueT'(i) ^ fillMask;
		end
	end

	assign data = (!en && !oe) ? mem[addr] : 'z;

	// Write lands as WE rises
	always @(posedge we) begin
		if (!en) begin
			mem[addr] = data;
		end
	end

endmodule

//////////////////////////////////////////////////
// Byte-wide serial chip
//////////////////////////////////////////////////

module uartModel import memBusPkg::*; (
	input logic clk,
	inout wire uartByteT uartData,
	input logic rdn,
	input logic wrn,
	output logic dataReady,
	output logic tbre,
	output logic tsre
);

	uartByteT rxQueue[$];
	uartByteT txLog[$];
	uartByteT rxHead;
	logic wrnArmed;
	integer seed = 80776;
	int waitClocks;

	initial begin
		dataReady = 1'b0;
		tbre = 1'b1;
		tsre = 1'b1;
		rxHead = 8'h00;
		wrnArmed = 1'b0;
	end

	task pushByte(input uartByteT b);
		rxQueue.push_back(b);
		rxHead = rxQueue[0];
	endtask

	always @(posedge clk) begin
		dataReady <= (rxQueue.size() != 0);
	end

	assign uartData = rdn ? 'z : rxHead;

	// Next byte shows up once rdn goes back high
	always @(posedge rdn) begin
		if (rxQueue.size() != 0) begin
			void'(rxQueue.pop_front());
			rxHead = (rxQueue.size() != 0) ? rxQueue[0] : 8'h00;
		end
	end

	// Only a real low pulse counts as a write, not the reset edge
	always @(negedge wrn) begin
		wrnArmed = 1'b1;
	end

	always @(posedge wrn) begin
		if (wrnArmed) begin
			wrnArmed = 1'b0;
			txLog.push_back(uartData);
			tbre <= 1'b0;
			tsre <= 1'b0;
			waitClocks = 1 + ({$random(seed)} % 6);
			repeat (waitClocks) @(posedge clk);
			tbre <= 1'b1;
			waitClocks = 1 + ({$random(seed)} % 6);
			repeat (waitClocks) @(posedge clk);
			tsre <= 1'b1;
		end
	end

endmodule

// ==== test/memBusTop_assert.sv ====
`timescale 1ns/10ps

module memBusTopAssert (
	input logic clk,
	input logic rst,
	input logic ram1En,
	input logic ram2En,
	input logic ram1Oe,
	input logic ram1We,
	input logic ram2Oe,
	input logic ram2We,
	input logic rdn,
	input logic wrn
);

	// Never both chips selected
	oneChipEnable: assert property (@(posedge clk) disable iff (!rst) (ram1En || ram2En))
		else $error("Both SRAM chip enables are low");

	serialStrobes: assert property (@(posedge clk) disable iff (!rst) (rdn || wrn))
		else $error("rdn and wrn are low together");

	// WE and OE are exclusive per chip
	ram1WeOe: assert property (@(posedge clk) disable iff (!rst) (ram1We || ram1Oe))
		else $error("Chip 1 has WE and OE low together");

	ram2WeOe: assert property (@(posedge clk) disable iff (!rst) (ram2We || ram2Oe))
		else $error("Chip 2 has WE and OE low together");

endmodule

bind memBusTop memBusTopAssert i_assert (
	.clk(clk),
	.rst(rst),
	.ram1En(ram1En),
	.ram2En(ram2En),
	.ram1Oe(ram1Oe),
	.ram1We(ram1We),
	.ram2Oe(ram2Oe),
	.ram2We(ram2We),
	.rdn(rdn),
	.wrn(wrn)
);

// ==== test/memBusTb.sv ====
`timescale 1ns/10ps
`include "memBusSettings.svh"

module memBusTb import memBusPkg::*; ();

	// About 46 accesses of some 20 clocks each plus serial waits
	// Roughly 1200 clocks in all with a wide margin on top
	localparam int cycleLimit = 4000;
	localparam memValueT ram1Fill = 16'hC3C3;
	localparam memValueT ram2Fill = 16'h3C3C;

	logic clk;
	logic rst;
	logic work;
	busReqT req;
	logic workDone;
	memValueT result;
	memAddrT ram1Addr;
	memAddrT ram2Addr;
	wire memValueT ram1Data;
	wire memValueT ram2Data;
	logic ram1En;
	logic ram1Oe;
	logic ram1We;
	logic ram2En;
	logic ram2Oe;
	logic ram2We;
	wire uartByteT uartData;
	logic rdn;
	logic wrn;
	logic dataReady;
	logic tbre;
	logic tsre;
	integer seed = 80776;
	int cycleCount = 0;
	int doneCount = 0;

	tbClock i_clock (.clk(clk), .rst(rst));

	memBusTop i_dut (
		.clk(clk), .rst(rst), .work(work), .req(req),
		.workDone(workDone), .result(result),
		.ram1Addr(ram1Addr), .ram1Data(ram1Data),
		.ram1En(ram1En), .ram1Oe(ram1Oe), .ram1We(ram1We),
		.ram2Addr(ram2Addr), .ram2Data(ram2Data),
		.ram2En(ram2En), .ram2Oe(ram2Oe), .ram2We(ram2We),
		.uartData(uartData), .rdn(rdn), .wrn(wrn),
		.dataReady(dataReady), .tbre(tbre), .tsre(tsre)
	);

	sramModel #(.fillMask(ram1Fill)) i_ram1Model (
		.addr(ram1Addr), .data(ram1Data), .en(ram1En), .oe(ram1Oe), .we(ram1We)
	);

	sramModel #(.fillMask(ram2Fill)) i_ram2Model (
		.addr(ram2Addr), .data(ram2Data), .en(ram2En), .oe(ram2Oe), .we(ram2We)
	);

	uartModel i_uartModel (
		.clk(clk), .uartData(uartData), .rdn(rdn), .wrn(wrn),
		.dataReady(dataReady), .tbre(tbre), .tsre(tsre)
	);

	//////////////////////////////////////////////////
	// Timeout and completion count
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (workDone === 1'b1) begin
			doneCount <= doneCount + 1;
		end
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", cycleLimit);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic checkValue(input memValueT got, input memValueT expected, input string what);
		if (got !== expected) begin
			$display("ERR %0d ns: %s is %h, expected %h", $time, what, got, expected);
			$display("TB FAILED");
			$fatal(1, "check failed");
		end
	endtask

	//////////////////////////////////////////////////
	// Bus access helpers
	//////////////////////////////////////////////////

	task automatic driveRequest(input logic write, input memAddrT addr, input memValueT value);
		busReqT r;
		r.write = write;
		r.addr = addr;
		r.value = value;
		@(posedge clk);
		work <= 1'b1;
		req <= r;
	endtask

	// Drop work in the clock after the pulse
	// The pulse is gone again one clock later
	task automatic waitDone(output memValueT readBack);
		do @(posedge clk); while (workDone !== 1'b1);
		work <= 1'b0;
		readBack = result;
		@(posedge clk);
		checkValue(memValueT'(workDone), 16'd0, "workDone one clock after its pulse");
	endtask

	task automatic access(input logic write, input memAddrT addr, input memValueT value,
		output memValueT readBack);
		driveRequest(write, addr, value);
		waitDone(readBack);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic resetLevels();
		wait (rst === 1'b1);
		@(posedge clk);
		checkValue(memValueT'(ram1En), 16'd1, "ram1En after reset");
		checkValue(memValueT'(ram1Oe), 16'd1, "ram1Oe after reset");
		checkValue(memValueT'(ram1We), 16'd1, "ram1We after reset");
		checkValue(memValueT'(ram2En), 16'd1, "ram2En after reset");
		checkValue(memValueT'(ram2Oe), 16'd1, "ram2Oe after reset");
		checkValue(memValueT'(ram2We), 16'd1, "ram2We after reset");
		checkValue(memValueT'(rdn), 16'd1, "rdn after reset");
		checkValue(memValueT'(wrn), 16'd1, "wrn after reset");
		checkValue(memValueT'(workDone), 16'd0, "workDone after reset");
		checkValue(ram1Data, 16'hzzzz, "ram1Data after reset");
		checkValue(ram2Data, 16'hzzzz, "ram2Data after reset");
		checkValue({8'h00, uartData}, 16'h00zz, "uartData after reset");
	endtask

	// Bit 15 picks the chip and the other one keeps its fill
	task automatic chipRoundTrip(input memAddrT addr);
		memValueT value;
		memValueT readBack;
		memValueT held;
		memValueT other;
		memValueT otherFill;
		value = memValueT'($random(seed));
		access(1'b1, addr, value, readBack);
		access(1'b0, addr, 16'h0000, readBack);
		checkValue(readBack, value, "SRAM read back");
		if (addr[15]) begin
			held = i_ram1Model.mem[addr];
			other = i_ram2Model.mem[addr];
			otherFill = ram2Fill;
		end else begin
			held = i_ram2Model.mem[addr];
			other = i_ram1Model.mem[addr];
			otherFill = ram1Fill;
		end
		checkValue(held, value, "word in the addressed SRAM model");
		checkValue(other, addr ^ otherFill, "word in the other SRAM model");
	endtask

	task automatic randomReadBack();
		memAddrT addrList[20];
		memValueT valueList[20];
		memValueT expected;
		memValueT readBack;
		for (int i = 0; i < 20; i++) begin
			addrList[i] = memAddrT'($random(seed));
			if (addrList[i] == `UART_ADDR) begin
				addrList[i] = addrList[i] ^ 16'h0001;
			end
			valueList[i] = memValueT'($random(seed));
			access(1'b1, addrList[i], valueList[i], readBack);
		end
		// Read back in reverse order
		// A repeated address keeps its last value
		for (int i = 19; i >= 0; i--) begin
			expected = valueList[i];
			for (int j = i + 1; j < 20; j++) begin
				if (addrList[j] == addrList[i]) begin
					expected = valueList[j];
				end
			end
			access(1'b0, addrList[i], 16'h0000, readBack);
			checkValue(readBack, expected, "random block read back");
		end
	endtask

	task automatic uartWriteOrder();
		memValueT value;
		memValueT readBack;
		value = memValueT'($random(seed));
		i_uartModel.txLog.delete();
		access(1'b1, `UART_ADDR, value, readBack);
		checkValue(memValueT'(i_uartModel.txLog.size()), 16'd2, "serial bytes logged");
		checkValue({8'h00, i_uartModel.txLog[0]}, {8'h00, value[15:8]}, "first serial byte");
		checkValue({8'h00, i_uartModel.txLog[1]}, {8'h00, value[7:0]}, "second serial byte");
	endtask

	task automatic uartDelayedRead();
		uartByteT high;
		uartByteT low;
		int doneBefore;
		memValueT readBack;
		high = uartByteT'($random(seed));
		low = uartByteT'($random(seed));
		doneBefore = doneCount;
		driveRequest(1'b0, `UART_ADDR, 16'h0000);
		repeat (24) @(posedge clk);
		@(negedge clk);
		i_uartModel.pushByte(high);
		repeat (24) @(posedge clk);
		checkValue(memValueT'(doneCount), memValueT'(doneBefore), "workDone before low byte");
		@(negedge clk);
		i_uartModel.pushByte(low);
		waitDone(readBack);
		checkValue(readBack, {high, low}, "serial read word");
	endtask

	initial begin
		work = 1'b0;
		req = '0;
		resetLevels();
		chipRoundTrip(16'hA35C);
		chipRoundTrip(16'h235C);
		randomReadBack();
		uartWriteOrder();
		uartDelayedRead();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== memBusTop.f ====
+incdir+verilog
verilog/memBusPkg.sv
verilog/sramPort.sv
verilog/uartPort.sv
verilog/memBusSequencer.sv
verilog/memBusTop.sv
test/tbClock.sv
test/memBusModels.sv
test/memBusTop_assert.sv
test/memBusTb.sv
